/* list.f */
+incdir+sim
rtl/prozessorPkg.sv
rtl/instruktionsdekodierer.sv
rtl/ablaufSteuerung.sv
rtl/registerSatz.sv
rtl/ladeSpeicherEinheit.sv
rtl/speicherArbiter.sv
rtl/hauptSpeicher.sv
rtl/befehlsEinheit.sv
sim/tbBefehlsEinheit.sv

/* rtl/ablaufSteuerung.sv */
`timescale 1ns/1ps

module ablaufSteuerung (
    input  logic        DekodierSignal,
    input  logic        arstN,
    input  logic        lauf,
    input  logic        holGewaehrt,
    input  logic        holGueltig,
    input  logic [31:0] speicherDaten,
    input  logic [5:0]  zielRegister,
    input  logic [25:0] iDaten,
    input  logic        jalBefehl,
    input  logic        relativerSprung,
    input  logic        absoluterSprung,
    input  logic        loadBefehl,
    input  logic        storeBefehl,
    input  logic        unbedingterSprungBefehl,
    input  logic        bedingterSprungBefehl,
    input  logic [31:0] leseWert1,
    input  logic        zugriffFertig,
    input  logic [31:0] ladeWert,
    output logic        holAnfrage,
    output logic [prozessorPkg::adressBreite-1:0] holAdresse,
    output logic        dekodieren,
    output logic [31:0] instruktion,
    output logic        zugriffStart,
    output logic        schreiben,
    output logic [prozessorPkg::adressBreite-1:0] zugriffAdresse,
    output logic        schreibFreigabe,
    output logic [5:0]  schreibNummer,
    output logic [31:0] schreibWert,
    output logic        retired,
    output logic [prozessorPkg::adressBreite-1:0] retiredPc
);
    import prozessorPkg::*;

    ablaufZustand zustand;
    ablaufZustand folgeZustand;
    logic [adressBreite-1:0] pc;
    logic [adressBreite-1:0] pcPlusEins;
    logic [adressBreite-1:0] sprungZiel;
    logic [adressBreite-1:0] naechsterPc;
    logic speicherBefehl;

    assign speicherBefehl = loadBefehl || storeBefehl;

    always_comb begin
        folgeZustand = zustand;
        case (zustand)
            zRuhe:           if (lauf) folgeZustand = zHolen;
            zHolen:          if (holGewaehrt) folgeZustand = zWarten;
            zWarten:         if (holGueltig) folgeZustand = zDekodieren;
            zDekodieren:     folgeZustand = zAusfuehren;
            zAusfuehren:     folgeZustand = speicherBefehl ? zSpeicher : zRueckschreiben;
            zSpeicher:       if (zugriffFertig) folgeZustand = zRueckschreiben;
            zRueckschreiben: folgeZustand = lauf ? zHolen : zRuhe;
            default:         folgeZustand = zRuhe;
        endcase
    end

    always_ff @(posedge DekodierSignal or negedge arstN) begin
        if (!arstN) begin
            zustand <= zRuhe;
            pc <= '0;
        end else begin
            zustand <= folgeZustand;
            if (zustand == zRueckschreiben) begin
                pc <= naechsterPc;
            end
        end
    end

    // Fetched word, handed to the decoder next cycle.
    always_ff @(posedge DekodierSignal) begin
        if (zustand == zWarten && holGueltig) begin
            instruktion <= speicherDaten;
        end
    end

    assign pcPlusEins = pc + 1'b1;
    assign sprungZiel = pc + iDaten[adressBreite-1:0];

    always_comb begin
        if (absoluterSprung) begin
            naechsterPc = iDaten[adressBreite-1:0];
        end else if (unbedingterSprungBefehl && relativerSprung) begin
            naechsterPc = sprungZiel;
        end else if (bedingterSprungBefehl && leseWert1 == 32'b0) begin
            naechsterPc = sprungZiel;
        end else begin
            naechsterPc = pcPlusEins;
        end
    end

    assign holAnfrage = (zustand == zHolen);
    assign holAdresse = pc;
    assign dekodieren = (zustand == zDekodieren);

    assign zugriffStart = (zustand == zAusfuehren) && speicherBefehl;
    assign schreiben = storeBefehl;
    assign zugriffAdresse = iDaten[adressBreite-1:0];

    // JAL links to the next word.
    assign retired = (zustand == zRueckschreiben);
    assign retiredPc = pc;
    assign schreibFreigabe = retired && (jalBefehl || loadBefehl);
    assign schreibNummer = jalBefehl ? linkRegister : zielRegister;
    assign schreibWert = jalBefehl ? {{(32-adressBreite){1'b0}}, pcPlusEins} : ladeWert;

endmodule

/* rtl/befehlsEinheit.sv */
`timescale 1ns/1ps

module befehlsEinheit (
    input  logic        DekodierSignal,
    input  logic        arstN,
    input  logic        lauf,
    input  logic        ladeAnfrage,
    input  logic [prozessorPkg::adressBreite-1:0] ladeAdresse,
    input  logic [31:0] ladeDaten,
    output logic        ladeGewaehrt,
    output logic        retired,
    output logic [prozessorPkg::adressBreite-1:0] retiredPc,
    output logic [5:0]  funktionsCode,
    output logic        floatBefehl,
    output logic        kleinerImmediateAktiv,
    output logic        grosserImmediateAktiv,
    output logic        schreibFreigabe,
    output logic [5:0]  schreibNummer,
    output logic [31:0] schreibWert,
    output logic        speicherSchreibt,
    output logic [prozessorPkg::adressBreite-1:0] speicherAdresse,
    output logic [31:0] speicherSchreibDaten
);

    logic        holAnfrage;
    logic        holGewaehrt;
    logic        holGueltig;
    logic [prozessorPkg::adressBreite-1:0] holAdresse;
    logic        datAnfrage;
    logic        datSchreiben;
    logic        datGewaehrt;
    logic        datGueltig;
    logic [prozessorPkg::adressBreite-1:0] datAdresse;
    logic [31:0] datSchreibDaten;
    logic        memFreigabe;
    logic [31:0] memLeseDaten;
    logic        dekodieren;
    logic [31:0] instruktion;
    logic [5:0]  quellRegister1;
    logic [5:0]  quellRegister2;
    logic [5:0]  zielRegister;
    logic [25:0] iDaten;
    logic        jalBefehl;
    logic        relativerSprung;
    logic        absoluterSprung;
    logic        loadBefehl;
    logic        storeBefehl;
    logic        unbedingterSprungBefehl;
    logic        bedingterSprungBefehl;
    logic [31:0] leseWert1;
    logic [31:0] leseWert2;
    logic        zugriffStart;
    logic        schreiben;
    logic [prozessorPkg::adressBreite-1:0] zugriffAdresse;
    logic        zugriffFertig;
    logic [31:0] ladeWert;

    instruktionsdekodierer dekodierer (.*);

    ablaufSteuerung steuerung (
        .speicherDaten (memLeseDaten),
        .*
    );

    registerSatz register (
        .leseNummer1 (quellRegister1),
        .leseNummer2 (quellRegister2),
        .*
    );

    ladeSpeicherEinheit ladeSpeicher (
        .speicherWert  (leseWert2),
        .speicherDaten (memLeseDaten),
        .*
    );

    // Write port of the memory doubles as the store observation port.
    speicherArbiter arbiter (
        .memSchreiben    (speicherSchreibt),
        .memAdresse      (speicherAdresse),
        .memSchreibDaten (speicherSchreibDaten),
        .*
    );

    hauptSpeicher speicher (
        .memSchreiben    (speicherSchreibt),
        .memAdresse      (speicherAdresse),
        .memSchreibDaten (speicherSchreibDaten),
        .*
    );

endmodule

/* rtl/hauptSpeicher.sv */
`timescale 1ns/1ps

module hauptSpeicher (
    input  logic        DekodierSignal,
    input  logic        memFreigabe,
    input  logic        memSchreiben,
    input  logic [prozessorPkg::adressBreite-1:0] memAdresse,
    input  logic [31:0] memSchreibDaten,
    output logic [31:0] memLeseDaten
);
    import prozessorPkg::*;

    logic [31:0] speicher [speicherTiefe];

    always_ff @(posedge DekodierSignal) begin
        if (memFreigabe) begin
            if (memSchreiben) begin
                speicher[memAdresse] <= memSchreibDaten;
            end else begin
                memLeseDaten <= speicher[memAdresse];
            end
        end
    end

endmodule

/* rtl/instruktionsdekodierer.sv */
`timescale 1ns/1ps

module instruktionsdekodierer (
    input  logic        DekodierSignal,
    input  logic        arstN,
    input  logic        dekodieren,
    input  logic [31:0] instruktion,
    output logic [5:0]  quellRegister1,
    output logic [5:0]  quellRegister2,
    output logic [5:0]  zielRegister,
    output logic [25:0] iDaten,
    output logic        kleinerImmediateAktiv,
    output logic        grosserImmediateAktiv,
    output logic [5:0]  funktionsCode,
    output logic        jalBefehl,
    output logic        relativerSprung,
    output logic        absoluterSprung,
    output logic        floatBefehl,
    output logic        loadBefehl,
    output logic        storeBefehl,
    output logic        unbedingterSprungBefehl,
    output logic        bedingterSprungBefehl
);
    import prozessorPkg::*;

    logic [31:0] befehl;
    logic [5:0]  opFeld;
    logic        registerKlasse;
    logic        floatKlasse;

    // Instruction held until the next strobe.
    always_ff @(posedge DekodierSignal or negedge arstN) begin
        if (!arstN) begin
            befehl <= '0;
        end else if (dekodieren) begin
            befehl <= instruktion;
        end
    end

    assign opFeld = befehl[31:26];
    assign registerKlasse = (befehl[31:30] == 2'b00);
    assign floatKlasse = registerKlasse && (befehl[5:4] == 2'b10);

    assign kleinerImmediateAktiv = befehl[31];
    assign grosserImmediateAktiv = (befehl[31:30] == 2'b01);
    assign floatBefehl = floatKlasse;

    // Bit 5 selects the float half of the register file.
    assign quellRegister1 = (registerKlasse || befehl[31]) ?
                            {floatKlasse, befehl[20:16]} : 6'b0;
    assign zielRegister = (registerKlasse || befehl[31]) ?
                          {floatKlasse, befehl[25:21]} : 6'b0;
    assign quellRegister2 = registerKlasse ? {floatKlasse, befehl[15:11]} :
                            (opFeld == opSpeichern) ? {1'b0, befehl[25:21]} :
                            6'b0;

    assign iDaten = grosserImmediateAktiv ? befehl[25:0] :
                    kleinerImmediateAktiv ? {10'b0, befehl[15:0]} :
                    26'b0;

    assign funktionsCode = registerKlasse ? befehl[5:0] :
                           grosserImmediateAktiv ? 6'b0 :
                           {1'b0, befehl[30:26]};

    assign jalBefehl = (opFeld == opSprungLink);
    assign absoluterSprung = (opFeld == opSprungAbs);
    assign relativerSprung = (opFeld == opSprungLink) || (opFeld == opSprungRel) ||
                             (opFeld == opSprungBed);
    assign loadBefehl = (opFeld == opLadenA) || (opFeld == opLadenB);
    assign storeBefehl = (opFeld == opSpeichern);
    assign unbedingterSprungBefehl = (opFeld == opSprungAbs) || (opFeld == opSprungLink) ||
                                     (opFeld == opSprungRel);
    assign bedingterSprungBefehl = (opFeld == opSprungBed);

endmodule

/* rtl/ladeSpeicherEinheit.sv */
`timescale 1ns/1ps

module ladeSpeicherEinheit (
    input  logic        DekodierSignal,
    input  logic        arstN,
    input  logic        zugriffStart,
    input  logic        schreiben,
    input  logic [prozessorPkg::adressBreite-1:0] zugriffAdresse,
    input  logic [31:0] speicherWert,
    input  logic        datGewaehrt,
    input  logic        datGueltig,
    input  logic [31:0] speicherDaten,
    output logic        datAnfrage,
    output logic        datSchreiben,
    output logic [prozessorPkg::adressBreite-1:0] datAdresse,
    output logic [31:0] datSchreibDaten,
    output logic        zugriffFertig,
    output logic [31:0] ladeWert
);

    // Request level held until the grant.
    always_ff @(posedge DekodierSignal or negedge arstN) begin
        if (!arstN) begin
            datAnfrage <= 1'b0;
            datSchreiben <= 1'b0;
        end else if (zugriffStart) begin
            datAnfrage <= 1'b1;
            datSchreiben <= schreiben;
        end else if (datGewaehrt) begin
            datAnfrage <= 1'b0;
        end
    end

    always_ff @(posedge DekodierSignal) begin
        if (zugriffStart) begin
            datAdresse <= zugriffAdresse;
            datSchreibDaten <= speicherWert;
        end
        if (datGueltig) begin
            ladeWert <= speicherDaten;
        end
    end

    // Stores finish on the grant, loads when data returns.
    assign zugriffFertig = (datGewaehrt && datSchreiben) || datGueltig;

endmodule

/* rtl/prozessorPkg.sv */
package prozessorPkg;

    localparam int speicherTiefe = 1024;
    localparam int adressBreite = 10;
    localparam int registerAnzahl = 64;
    localparam logic [5:0] linkRegister = 6'd31;

    // Top six opcode bits of the executed classes.
    typedef enum logic [5:0] {
        opLadenA     = 6'b101010,
        opLadenB     = 6'b101011,
        opSpeichern  = 6'b101100,
        opSprungAbs  = 6'b101101,
        opSprungBed  = 6'b101110,
        opSprungLink = 6'b101111,
        opSprungRel  = 6'b010000
    } befehlsOpcode;

    typedef enum logic [2:0] {
        zRuhe,
        zHolen,
        zWarten,
        zDekodieren,
        zAusfuehren,
        zSpeicher,
        zRueckschreiben
    } ablaufZustand;

endpackage

/* rtl/registerSatz.sv */
`timescale 1ns/1ps

module registerSatz (
    input  logic        DekodierSignal,
    input  logic        arstN,
    input  logic [5:0]  leseNummer1,
    input  logic [5:0]  leseNummer2,
    input  logic        schreibFreigabe,
    input  logic [5:0]  schreibNummer,
    input  logic [31:0] schreibWert,
    output logic [31:0] leseWert1,
    output logic [31:0] leseWert2
);
    import prozessorPkg::*;

    // Integer registers 0 to 31, float registers 32 to 63.
    logic [31:0] register [registerAnzahl];

    always_ff @(posedge DekodierSignal or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < registerAnzahl; i++) begin
                register[i] <= '0;
            end
        end else if (schreibFreigabe) begin
            register[schreibNummer] <= schreibWert;
        end
    end

    assign leseWert1 = register[leseNummer1];
    assign leseWert2 = register[leseNummer2];

endmodule

/* rtl/speicherArbiter.sv */
`timescale 1ns/1ps

module speicherArbiter (
    input  logic        DekodierSignal,
    input  logic        arstN,
    input  logic        ladeAnfrage,
    input  logic [prozessorPkg::adressBreite-1:0] ladeAdresse,
    input  logic [31:0] ladeDaten,
    input  logic        datAnfrage,
    input  logic        datSchreiben,
    input  logic [prozessorPkg::adressBreite-1:0] datAdresse,
    input  logic [31:0] datSchreibDaten,
    input  logic        holAnfrage,
    input  logic [prozessorPkg::adressBreite-1:0] holAdresse,
    output logic        ladeGewaehrt,
    output logic        datGewaehrt,
    output logic        datGueltig,
    output logic        holGewaehrt,
    output logic        holGueltig,
    output logic        memFreigabe,
    output logic        memSchreiben,
    output logic [prozessorPkg::adressBreite-1:0] memAdresse,
    output logic [31:0] memSchreibDaten
);

    // Host first, then data, then fetch.
    assign ladeGewaehrt = ladeAnfrage;
    assign datGewaehrt = datAnfrage && !ladeAnfrage;
    assign holGewaehrt = holAnfrage && !ladeAnfrage && !datAnfrage;

    assign memFreigabe = ladeGewaehrt || datGewaehrt || holGewaehrt;
    assign memSchreiben = ladeGewaehrt || (datGewaehrt && datSchreiben);
    assign memAdresse = ladeGewaehrt ? ladeAdresse :
                        datGewaehrt ? datAdresse :
                        holAdresse;
    assign memSchreibDaten = ladeGewaehrt ? ladeDaten : datSchreibDaten;

    // Flags which requester owns the returning read word.
    always_ff @(posedge DekodierSignal or negedge arstN) begin
        if (!arstN) begin
            datGueltig <= 1'b0;
            holGueltig <= 1'b0;
        end else begin
            datGueltig <= datGewaehrt && !datSchreiben;
            holGueltig <= holGewaehrt;
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -sv -f list.f --top-module tbBefehlsEinheit -o tbSim &&
ausgabe="$(./obj_dir/tbSim)" &&
echo "$ausgabe" &&
echo "$ausgabe" | grep -qx '>>> PASS' &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* sim/referenzModell.svh */
`ifndef REFERENZMODELL_SVH
`define REFERENZMODELL_SVH

// Architectural image, stepped once per retired instruction.
logic [31:0] modellSpeicher [speicherTiefe];
logic [31:0] modellRegister [registerAnzahl];
logic [adressBreite-1:0] modellPc;

logic [adressBreite-1:0] sollPc;
logic        sollFreigabe;
logic [5:0]  sollNummer;
logic [31:0] sollWert;
int          sollSchreibZahl;
logic [adressBreite-1:0] sollAdresse;
logic [31:0] sollDaten;
logic [5:0]  sollFunktion;
logic        sollFloat;
logic        sollKlein;
logic        sollGross;

task automatic modellZuruecksetzen();
    modellPc = '0;
    for (int i = 0; i < registerAnzahl; i++) begin
        modellRegister[i[5:0]] = '0;
    end
endtask

task automatic modellSchritt();
    logic [31:0] wort;
    logic [adressBreite-1:0] imm;
    logic [adressBreite-1:0] folgePc;
    wort = modellSpeicher[modellPc];
    imm = wort[adressBreite-1:0];
    folgePc = modellPc + 1'b1;
    sollPc = modellPc;
    sollFreigabe = 1'b0;
    sollNummer = '0;
    sollWert = '0;
    sollSchreibZahl = 0;
    // Decoded fields follow the word class only.
    sollKlein = wort[31];
    sollGross = (wort[31:30] == 2'b01);
    sollFloat = (wort[31:30] == 2'b00) && (wort[5:4] == 2'b10);
    if (wort[31:30] == 2'b00) begin
        sollFunktion = wort[5:0];
    end else if (sollGross) begin
        sollFunktion = '0;
    end else begin
        sollFunktion = {1'b0, wort[30:26]};
    end
    case (wort[31:26])
        opLadenA, opLadenB: begin
            sollFreigabe = 1'b1;
            sollNummer = {1'b0, wort[25:21]};
            sollWert = modellSpeicher[imm];
        end
        opSpeichern: begin
            sollSchreibZahl = 1;
            sollAdresse = imm;
            sollDaten = modellRegister[{1'b0, wort[25:21]}];
            modellSpeicher[imm] = sollDaten;
        end
        opSprungAbs: folgePc = imm;
        opSprungRel: folgePc = modellPc + imm;
        opSprungBed: begin
            if (modellRegister[{1'b0, wort[20:16]}] == 32'b0) begin
                folgePc = modellPc + imm;
            end
        end
        opSprungLink: begin
            sollFreigabe = 1'b1;
            sollNummer = linkRegister;
            sollWert = {{(32-adressBreite){1'b0}}, folgePc};
            folgePc = modellPc + imm;
        end
        default: begin
        end
    endcase
    if (sollFreigabe) begin
        modellRegister[sollNummer] = sollWert;
    end
    modellPc = folgePc;
endtask

`endif

/* sim/tbBefehlsEinheit.sv */
`timescale 1ns/1ps

module tbBefehlsEinheit;
    import prozessorPkg::*;

    localparam int periode = 8;
    localparam int ersteRunde = 300;
    localparam int zweiteRunde = 40;
    localparam int dritteRunde = 60;
    localparam int ruhePhase = 50;
    localparam int grenzeZyklen = 32 + speicherTiefe + 2 * ruhePhase
                                  + 200 * (ersteRunde + zweiteRunde + dritteRunde + 2);

    logic        DekodierSignal;
    logic        arstN;
    logic        lauf;
    logic        ladeAnfrage;
    logic [adressBreite-1:0] ladeAdresse;
    logic [31:0] ladeDaten;
    logic        ladeGewaehrt;
    logic        retired;
    logic [adressBreite-1:0] retiredPc;
    logic [5:0]  funktionsCode;
    logic        floatBefehl;
    logic        kleinerImmediateAktiv;
    logic        grosserImmediateAktiv;
    logic        schreibFreigabe;
    logic [5:0]  schreibNummer;
    logic [31:0] schreibWert;
    logic        speicherSchreibt;
    logic [adressBreite-1:0] speicherAdresse;
    logic [31:0] speicherSchreibDaten;

    logic [31:0] lfsr;
    int retireZahl;
    int schreibZahl;
    logic [adressBreite-1:0] beobAdresse;
    logic [31:0] beobDaten;
    logic [adressBreite-1:0] letzterPc;
    int pcFehler;
    int rueckFehler;
    int speicherFehler;
    int feldFehler;
    int sonstFehler;

    `include "referenzModell.svh"

    befehlsEinheit dut (.*);

    always #(periode / 2) DekodierSignal = ~DekodierSignal;

    // Galois LFSR, one step per bit taken.
    function automatic logic [31:0] zufall(input int breite);
        logic [31:0] wert;
        logic bit0;
        wert = '0;
        for (int i = 0; i < breite; i++) begin
            bit0 = lfsr[0];
            lfsr = lfsr >> 1;
            if (bit0) begin
                lfsr = lfsr ^ 32'hA300_0000;
            end
            wert = {wert[30:0], bit0};
        end
        return wert;
    endfunction

    // Memory operands stay in the upper half, jumps land in the lower half.
    function automatic logic [31:0] befehlErzeugen();
        logic [31:0] klasse;
        logic [31:0] wahl;
        logic [31:0] feld;
        logic [31:0] adr;
        logic [3:0]  weite;
        klasse = zufall(3);
        wahl = zufall(1);
        feld = zufall(30);
        adr = zufall(9);
        weite = {1'b0, adr[2:0]} + 4'd1;
        case (klasse[2:0])
            3'd0: return {(wahl[0] ? opLadenB : opLadenA), feld[15:0], 1'b1, adr[8:0]};
            3'd1: return {opSpeichern, feld[15:0], 1'b1, adr[8:0]};
            3'd2: return {opSprungAbs, feld[15:0], 1'b0, adr[8:0]};
            3'd3: return {opSprungBed, feld[15:0], 6'b0, weite};
            3'd4: return {opSprungLink, feld[15:0], 6'b0, weite};
            3'd5: return {opSprungRel, feld[15:0], 6'b0, weite};
            3'd6: return {2'b00, feld[29:0]};
            default: return wahl[0] ? {2'b11, feld[29:0]} : {3'b011, feld[28:0]};
        endcase
    endfunction

    task automatic wortLaden(input logic [adressBreite-1:0] adresse, input logic [31:0] daten);
        @(negedge DekodierSignal);
        ladeAnfrage = 1'b1;
        ladeAdresse = adresse;
        ladeDaten = daten;
        @(posedge DekodierSignal);
        while (!ladeGewaehrt) begin
            @(posedge DekodierSignal);
        end
    endtask

    task automatic pcVergleich(input logic [adressBreite-1:0] ist);
        if (ist !== sollPc) begin
            $display("MISMATCH retiredPc: got 0x%h, expected 0x%h", ist, sollPc);
            pcFehler++;
        end
    endtask

    task automatic rueckschreibVergleich(input logic freigabe, input logic [5:0] nummer,
                                         input logic [31:0] wert);
        if (freigabe !== sollFreigabe) begin
            $display("MISMATCH schreibFreigabe at pc 0x%h: got 0x%h, expected 0x%h",
                     sollPc, freigabe, sollFreigabe);
            rueckFehler++;
        end else if (freigabe && (nummer !== sollNummer || wert !== sollWert)) begin
            $display("MISMATCH schreibNummer/schreibWert: got 0x%h/0x%h, expected 0x%h/0x%h",
                     nummer, wert, sollNummer, sollWert);
            rueckFehler++;
        end
    endtask

    task automatic speicherVergleich(input logic [adressBreite-1:0] adresse,
                                     input logic [31:0] daten);
        if (schreibZahl != sollSchreibZahl) begin
            $display("Instruction at pc 0x%h made %0d memory writes instead of %0d",
                     sollPc, schreibZahl, sollSchreibZahl);
            speicherFehler++;
        end else if (sollSchreibZahl == 1 && (adresse !== sollAdresse || daten !== sollDaten)) begin
            $display("MISMATCH speicherAdresse/speicherSchreibDaten: got 0x%h/0x%h, expected 0x%h/0x%h",
                     adresse, daten, sollAdresse, sollDaten);
            speicherFehler++;
        end
    endtask

    task automatic feldVergleich(input logic [5:0] funktion, input logic float,
                                 input logic klein, input logic gross);
        if ({funktion, float, klein, gross} !== {sollFunktion, sollFloat, sollKlein, sollGross}) begin
            $display("MISMATCH funktionsCode/floatBefehl/kleinerImm/grosserImm: got 0x%h, expected 0x%h",
                     {funktion, float, klein, gross}, {sollFunktion, sollFloat, sollKlein, sollGross});
            feldFehler++;
        end
    endtask

    // Outputs settle during the cycle and are sampled at the rising edge.
    always @(posedge DekodierSignal) begin
        if (arstN) begin
            if (speicherSchreibt && !ladeGewaehrt) begin
                schreibZahl++;
                beobAdresse = speicherAdresse;
                beobDaten = speicherSchreibDaten;
            end
            if (retired) begin
                modellSchritt();
                pcVergleich(retiredPc);
                rueckschreibVergleich(schreibFreigabe, schreibNummer, schreibWert);
                speicherVergleich(beobAdresse, beobDaten);
                feldVergleich(funktionsCode, floatBefehl, kleinerImmediateAktiv,
                              grosserImmediateAktiv);
                schreibZahl = 0;
                letzterPc = retiredPc;
                retireZahl++;
            end
        end
    end

    initial begin
        #(grenzeZyklen * periode);
        $display("Timeout: the unit stopped retiring instructions");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int basis;
        int gesamt;
        DekodierSignal = 1'b0;
        arstN = 1'b0;
        lauf = 1'b0;
        ladeAnfrage = 1'b0;
        ladeAdresse = '0;
        ladeDaten = '0;
        lfsr = 32'd30;
        retireZahl = 0;
        schreibZahl = 0;
        pcFehler = 0;
        rueckFehler = 0;
        speicherFehler = 0;
        feldFehler = 0;
        sonstFehler = 0;
        modellZuruecksetzen();
        for (int i = 0; i < speicherTiefe; i++) begin
            modellSpeicher[i[adressBreite-1:0]] = (i < speicherTiefe / 2) ?
                                                   befehlErzeugen() : zufall(32);
        end
        repeat (16) @(negedge DekodierSignal);
        arstN = 1'b1;
        for (int i = 0; i < speicherTiefe; i++) begin
            wortLaden(i[adressBreite-1:0], modellSpeicher[i[adressBreite-1:0]]);
        end
        @(negedge DekodierSignal);
        ladeAnfrage = 1'b0;
        lauf = 1'b1;
        wait (retireZahl >= ersteRunde);

        // Stop request, at most the instruction in flight may retire.
        @(negedge DekodierSignal);
        lauf = 1'b0;
        basis = retireZahl;
        repeat (ruhePhase) @(negedge DekodierSignal);
        if (retireZahl - basis > 1) begin
            $display("Unit retired %0d instructions after lauf fell", retireZahl - basis);
            sonstFehler++;
        end

        lauf = 1'b1;
        wait (retireZahl >= basis + zweiteRunde);
        @(negedge DekodierSignal);
        arstN = 1'b0;
        modellZuruecksetzen();
        schreibZahl = 0;
        repeat (16) @(negedge DekodierSignal);
        arstN = 1'b1;
        basis = retireZahl;
        wait (retireZahl > basis);
        if (letzterPc !== '0) begin
            $display("MISMATCH retiredPc after reset: got 0x%h, expected 0x000", letzterPc);
            pcFehler++;
        end

        wait (retireZahl >= basis + dritteRunde);
        @(negedge DekodierSignal);
        lauf = 1'b0;
        repeat (ruhePhase) @(negedge DekodierSignal);
        gesamt = pcFehler + rueckFehler + speicherFehler + feldFehler + sonstFehler;
        $display("Errors: pc %0d, writeback %0d, store %0d, fields %0d, other %0d",
                 pcFehler, rueckFehler, speicherFehler, feldFehler, sonstFehler);
        if (gesamt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
